// File: common/rvDecodePkg.sv
// shared decode types; named core registers sit at 64 and up, so 011111 CSR maps may overlap them
package rvDecodePkg;

	// 7-bit core register index, 0 to 31 are the numbered registers
	typedef logic [6:0] regIdx_t;

	// decoded immediate, bit 32 carries the sign
	typedef logic [32:0] imm_t;

	// special registers of the core
	localparam regIdx_t regZzr   = 7'h40;
	localparam regIdx_t regLr    = 7'h41;
	localparam regIdx_t regSp    = 7'h42;
	localparam regIdx_t regGbr   = 7'h43;
	localparam regIdx_t regTbr   = 7'h44;
	localparam regIdx_t regDhr   = 7'h45;
	localparam regIdx_t regDlr   = 7'h46;
	localparam regIdx_t regPc    = 7'h47;
	localparam regIdx_t regImm   = 7'h48;
	localparam regIdx_t regCpuid = 7'h49;

	// micro-op commands, cmdInvOp must stay at zero
	typedef enum logic [5:0] {
		cmdInvOp  = 6'd0,
		cmdMovMr  = 6'd1,
		cmdMovRm  = 6'd2,
		cmdJcmp   = 6'd3,
		cmdJsr    = 6'd4,
		cmdJmp    = 6'd5,
		cmdAlu3   = 6'd6,
		cmdShad3  = 6'd7,
		cmdMulDiv = 6'd8,
		cmdIxt    = 6'd9,
		cmdMovRc  = 6'd10,
		cmdMovCr  = 6'd11,
		cmdLeaMr  = 6'd12,
		cmdMovIr  = 6'd13
	} uCmd_t;

	// index inside a command, idxNone is the reset value
	typedef enum logic [5:0] {
		idxNone    = 6'd0,
		// ALU
		idxAdd     = 6'd1,
		idxSub     = 6'd2,
		idxSlts    = 6'd3,
		idxSltu    = 6'd4,
		idxXor     = 6'd5,
		idxOr      = 6'd6,
		idxAnd     = 6'd7,
		// shifts
		idxShl     = 6'd8,
		idxShr     = 6'd9,
		idxSar     = 6'd10,
		// multiply and divide
		idxMul     = 6'd11,
		idxMulhs   = 6'd12,
		idxMulhsu  = 6'd13,
		idxMulhu   = 6'd14,
		idxDivs    = 6'd15,
		idxDivu    = 6'd16,
		idxMods    = 6'd17,
		idxModu    = 6'd18,
		// compare and branch
		idxEq      = 6'd19,
		idxNe      = 6'd20,
		idxLt      = 6'd21,
		idxGe      = 6'd22,
		idxLtu     = 6'd23,
		idxGeu     = 6'd24,
		// system
		idxSyscall = 6'd25,
		idxBreak   = 6'd26,
		idxRte     = 6'd27,
		idxSleep   = 6'd28,
		idxCpuid   = 6'd29
	} uIdx_t;

	// how the register fields feed the N, M and O selectors
	typedef enum logic [2:0] {
		formNone      = 3'd0,
		formRegReg    = 3'd1,
		formRegImmReg = 3'd2,
		formLoad      = 3'd3,
		formStore     = 3'd4,
		formBranch    = 3'd5,
		formPcDisp    = 3'd6,
		formImmReg    = 3'd7
	} opForm_t;

	// immediate layouts of the base encodings
	typedef enum logic [2:0] {
		immNone = 3'd0,
		immI    = 3'd1,
		immS    = 3'd2,
		immB    = 3'd3,
		immJ    = 3'd4,
		immU    = 3'd5
	} immKind_t;

endpackage

// File: decode/regFieldMap.sv
// combinational only; CSRs outside the 011111, 101111 and 111111 groups read as the zero register
`timescale 1ns/1ps

module regFieldMap (
	input  logic [31:0]          inWord,
	output rvDecodePkg::regIdx_t mapN,
	output rvDecodePkg::regIdx_t mapM,
	output rvDecodePkg::regIdx_t mapO,
	output rvDecodePkg::regIdx_t mapCsr,
	output logic                 csrIsCpuid
);
	import rvDecodePkg::*;

	// low sixteen fields alias onto special registers
	function automatic regIdx_t mapGpr(input logic [4:0] field);
		regIdx_t idx;
		idx = {2'b00, field};
		if (!field[4]) begin
			case (field[3:0])
				4'd0: idx = regZzr;
				4'd1: idx = regLr;
				4'd2: idx = regSp;
				4'd3: idx = regGbr;
				4'd4: idx = regTbr;
				4'd5: idx = regDhr;
				// 14 and 15 fold onto R2 and R3
				4'd14: idx = 7'd2;
				4'd15: idx = 7'd3;
				default: idx = {2'b00, field};
			endcase
		end
		return idx;
	endfunction

	assign mapN = mapGpr(inWord[11:7]);
	assign mapM = mapGpr(inWord[19:15]);
	assign mapO = mapGpr(inWord[24:20]);

	always_comb begin
		mapCsr = regZzr;
		csrIsCpuid = 1'b0;
		casez (inWord[31:26])
			// control register space, bit 5 inverted
			6'b011111: begin
				mapCsr = {1'b1, ~inWord[25], inWord[24:20]};
			end
			6'b101111: begin
				mapCsr = {1'b0, inWord[25:20]};
			end
			// CPUID window, low bits give the leaf
			6'b111111: begin
				mapCsr = {1'b0, inWord[25:20]};
				csrIsCpuid = 1'b1;
			end
			default: begin
				mapCsr = regZzr;
			end
		endcase
	end

endmodule

// File: decode/opClassify.sv
// combinational; only the RV32I base, M group and SYSTEM subset are kept, the rest decode as cmdInvOp
`timescale 1ns/1ps

module opClassify (
	input  logic [31:0]           inWord,
	output rvDecodePkg::uCmd_t    clsCmd,
	output rvDecodePkg::uIdx_t    clsIdx,
	output rvDecodePkg::opForm_t  clsForm,
	output rvDecodePkg::immKind_t clsImm,
	output logic [2:0]            clsWidth
);
	import rvDecodePkg::*;

	logic [4:0] opcode;
	logic [2:0] funct3;
	logic       alt;
	logic       isMulDiv;
	logic       isShift;
	logic       rdZero;
	logic       rs1Zero;
	logic       csrCpuid;

	assign opcode   = inWord[6:2];
	assign funct3   = inWord[14:12];
	// bit 30 picks sub and arithmetic shift
	assign alt      = inWord[30];
	assign isMulDiv = (inWord[31:25] == 7'h01);
	assign isShift  = (funct3[1:0] == 2'b01);
	assign rdZero   = (inWord[11:7] == 5'd0);
	assign rs1Zero  = (inWord[19:15] == 5'd0);
	assign csrCpuid = (inWord[31:26] == 6'b111111);

	// shared by OP and OP-IMM, sub only exists in the register form
	function automatic uIdx_t aluIndex(input logic [2:0] f3, input logic a, input logic isReg);
		uIdx_t idx;
		case (f3)
			3'b000: idx = (isReg && a) ? idxSub : idxAdd;
			3'b001: idx = idxShl;
			3'b010: idx = idxSlts;
			3'b011: idx = idxSltu;
			3'b100: idx = idxXor;
			3'b101: idx = a ? idxSar : idxShr;
			3'b110: idx = idxOr;
			default: idx = idxAnd;
		endcase
		return idx;
	endfunction

	always_comb begin
		clsCmd   = cmdInvOp;
		clsIdx   = idxNone;
		clsForm  = formNone;
		clsImm   = immNone;
		clsWidth = 3'b000;
		if (inWord[1:0] == 2'b11) begin
			case (opcode)
				// LOAD
				5'b00000: begin
					clsCmd   = cmdMovMr;
					clsForm  = formLoad;
					clsImm   = immI;
					clsWidth = funct3;
				end
				// STORE
				5'b01000: begin
					clsCmd   = cmdMovRm;
					clsForm  = formStore;
					clsImm   = immS;
					clsWidth = funct3;
				end
				// BRANCH, reserved 010 and 011 fall back to eq
				5'b11000: begin
					clsCmd  = cmdJcmp;
					clsForm = formBranch;
					clsImm  = immB;
					case (funct3)
						3'b001: clsIdx = idxNe;
						3'b100: clsIdx = idxLt;
						3'b101: clsIdx = idxGe;
						3'b110: clsIdx = idxLtu;
						3'b111: clsIdx = idxGeu;
						default: clsIdx = idxEq;
					endcase
				end
				// JALR
				5'b11001: begin
					clsCmd  = cmdJsr;
					clsForm = formRegImmReg;
					clsImm  = immI;
				end
				// JAL
				5'b11011: begin
					clsCmd  = cmdJsr;
					clsForm = formPcDisp;
					clsImm  = immJ;
				end
				// OP-IMM
				5'b00100: begin
					clsCmd  = isShift ? cmdShad3 : cmdAlu3;
					clsIdx  = aluIndex(funct3, alt, 1'b0);
					clsForm = formRegImmReg;
					clsImm  = immI;
				end
				// OP, funct7 of 1 is the multiply/divide group
				5'b01100: begin
					clsForm = formRegReg;
					if (isMulDiv) begin
						clsCmd = cmdMulDiv;
						case (funct3)
							3'b000: clsIdx = idxMul;
							3'b001: clsIdx = idxMulhs;
							3'b010: clsIdx = idxMulhsu;
							3'b011: clsIdx = idxMulhu;
							3'b100: clsIdx = idxDivs;
							3'b101: clsIdx = idxDivu;
							3'b110: clsIdx = idxMods;
							default: clsIdx = idxModu;
						endcase
					end else begin
						clsCmd = isShift ? cmdShad3 : cmdAlu3;
						clsIdx = aluIndex(funct3, alt, 1'b1);
					end
				end
				// AUIPC
				5'b00101: begin
					clsCmd  = cmdLeaMr;
					clsForm = formPcDisp;
					clsImm  = immU;
				end
				// LUI
				5'b01101: begin
					clsCmd  = cmdMovIr;
					clsForm = formImmReg;
					clsImm  = immU;
				end
				// SYSTEM
				5'b11100: begin
					case (funct3)
						3'b000: begin
							case (inWord[23:20])
								4'h0: clsIdx = idxSyscall;
								4'h1: clsIdx = idxBreak;
								4'h2: clsIdx = idxRte;
								4'h5: clsIdx = idxSleep;
								default: clsIdx = idxNone;
							endcase
							if (clsIdx != idxNone) begin
								clsCmd = cmdIxt;
							end
						end
						3'b001: begin
							if (rdZero) begin
								clsCmd  = cmdMovRc;
								clsForm = formRegReg;
							end
						end
						3'b010, 3'b011: begin
							if (rs1Zero) begin
								clsCmd  = cmdMovCr;
								clsForm = formRegReg;
							end
							// CPUID only on the read form
							if (csrCpuid && !funct3[0]) begin
								clsCmd  = cmdIxt;
								clsIdx  = idxCpuid;
								clsForm = formRegReg;
							end
						end
						default: begin
							clsCmd = cmdInvOp;
						end
					endcase
				end
				default: begin
					clsCmd = cmdInvOp;
				end
			endcase
		end
	end

endmodule

// File: decode/operandSelect.sv
// combinational; clock and rst only feed the checks, user mode refuses any rd field of 4
`timescale 1ns/1ps

module operandSelect #(
	parameter bit StallAssertions = 1'b1
) (
	input  logic                  clock,
	input  logic                  rst,
	input  logic [31:0]           inWord,
	input  logic                  userMode,
	input  rvDecodePkg::regIdx_t  mapN,
	input  rvDecodePkg::regIdx_t  mapM,
	input  rvDecodePkg::regIdx_t  mapO,
	input  rvDecodePkg::regIdx_t  mapCsr,
	input  logic                  csrIsCpuid,
	input  rvDecodePkg::uCmd_t    clsCmd,
	input  rvDecodePkg::uIdx_t    clsIdx,
	input  rvDecodePkg::opForm_t  clsForm,
	input  rvDecodePkg::immKind_t clsImm,
	input  logic [2:0]            clsWidth,
	output rvDecodePkg::uCmd_t    selCmd,
	output rvDecodePkg::uIdx_t    selIdx,
	output rvDecodePkg::regIdx_t  selRegN,
	output rvDecodePkg::regIdx_t  selRegM,
	output rvDecodePkg::regIdx_t  selRegO,
	output rvDecodePkg::imm_t     selImm
);
	import rvDecodePkg::*;

	logic rdZero;
	logic refused;

	assign rdZero  = (inWord[11:7] == 5'd0);
	// raw rd field, before aliasing
	assign refused = userMode && (inWord[11:7] == 5'd4);

	always_comb begin
		case (clsImm)
			immI: selImm = {{21{inWord[31]}}, inWord[31:20]};
			immS: selImm = {{21{inWord[31]}}, inWord[31:25], inWord[11:7]};
			// branch displacement stays in halfword units
			immB: selImm = {{21{inWord[31]}}, inWord[31], inWord[7], inWord[30:25], inWord[11:8]};
			immJ: selImm = {{14{inWord[31]}}, inWord[19:12], inWord[20], inWord[30:21]};
			immU: selImm = {1'b0, inWord[31:12], 12'h000};
			default: selImm = '0;
		endcase
	end

	always_comb begin
		selRegN = regZzr;
		selRegM = regZzr;
		selRegO = regZzr;
		case (clsForm)
			formRegReg: begin
				selRegN = mapN;
				selRegM = mapM;
				selRegO = mapO;
				if (clsCmd == cmdMovCr) begin
					selRegM = mapCsr;
				end
				if (clsCmd == cmdMovRc) begin
					selRegN = mapCsr;
				end
				// leaf number in M, CPUID source in O
				if (clsCmd == cmdIxt && csrIsCpuid) begin
					selRegM = mapCsr;
					selRegO = regCpuid;
				end
			end
			formRegImmReg, formLoad: begin
				selRegN = mapN;
				selRegM = mapM;
				selRegO = regImm;
			end
			formStore: begin
				selRegN = mapO;
				selRegM = mapM;
				selRegO = regImm;
			end
			formBranch: begin
				selRegM = mapM;
				selRegO = mapO;
			end
			formPcDisp: begin
				selRegN = mapN;
				selRegM = regPc;
				selRegO = regImm;
			end
			formImmReg: begin
				selRegN = mapN;
				selRegM = regImm;
			end
			default: begin
				selRegN = regZzr;
			end
		endcase
	end

	always_comb begin
		selCmd = clsCmd;
		// link to the zero register is a plain jump
		if (clsCmd == cmdJsr && rdZero) begin
			selCmd = cmdJmp;
		end
		if (refused) begin
			selCmd = cmdInvOp;
		end
	end

	assign selIdx = clsIdx;

	refuseCheck: assert property (@(posedge clock) disable iff (rst)
		refused |-> selCmd == cmdInvOp);

	if (StallAssertions) begin : gStable
		// a held word keeps the whole micro-op steady
		holdCheck: assert property (@(posedge clock) disable iff (rst)
			$stable(inWord) && $stable(userMode) |->
				$stable(selCmd) && $stable(selIdx) && $stable(selImm) &&
				$stable(selRegN) && $stable(selRegM) && $stable(selRegO));
	end

endmodule

// File: logic/rvDecodeStage.sv
// one-entry registered decode stage; accepts one word per cycle, result valid one cycle later
`timescale 1ns/1ps

module rvDecodeStage #(
	parameter bit StallAssertions = 1'b1
) (
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 inValid,
	input  logic [31:0]          inWord,
	input  logic                 userMode,
	input  logic                 outReady,
	output logic                 inReady,
	output logic                 outValid,
	output rvDecodePkg::uCmd_t   outCmd,
	output rvDecodePkg::uIdx_t   outIdx,
	output rvDecodePkg::regIdx_t outRegN,
	output rvDecodePkg::regIdx_t outRegM,
	output rvDecodePkg::regIdx_t outRegO,
	output rvDecodePkg::imm_t    outImm,
	output logic [2:0]           outWidth
);
	import rvDecodePkg::*;

	regIdx_t  mapN;
	regIdx_t  mapM;
	regIdx_t  mapO;
	regIdx_t  mapCsr;
	logic     csrIsCpuid;
	uCmd_t    clsCmd;
	uIdx_t    clsIdx;
	opForm_t  clsForm;
	immKind_t clsImm;
	logic [2:0] clsWidth;
	uCmd_t    selCmd;
	uIdx_t    selIdx;
	regIdx_t  selRegN;
	regIdx_t  selRegM;
	regIdx_t  selRegO;
	imm_t     selImm;

	regFieldMap fieldMap (
		.inWord(inWord),
		.mapN(mapN),
		.mapM(mapM),
		.mapO(mapO),
		.mapCsr(mapCsr),
		.csrIsCpuid(csrIsCpuid)
	);

	opClassify classify (
		.inWord(inWord),
		.clsCmd(clsCmd),
		.clsIdx(clsIdx),
		.clsForm(clsForm),
		.clsImm(clsImm),
		.clsWidth(clsWidth)
	);

	operandSelect #(
		.StallAssertions(StallAssertions)
	) select (
		.clock(clock),
		.rst(rst),
		.inWord(inWord),
		.userMode(userMode),
		.mapN(mapN),
		.mapM(mapM),
		.mapO(mapO),
		.mapCsr(mapCsr),
		.csrIsCpuid(csrIsCpuid),
		.clsCmd(clsCmd),
		.clsIdx(clsIdx),
		.clsForm(clsForm),
		.clsImm(clsImm),
		.clsWidth(clsWidth),
		.selCmd(selCmd),
		.selIdx(selIdx),
		.selRegN(selRegN),
		.selRegM(selRegM),
		.selRegO(selRegO),
		.selImm(selImm)
	);

	// free slot, or the held result leaves this edge
	assign inReady = !outValid || outReady;

	always_ff @(posedge clock) begin
		if (rst) begin
			outValid <= 1'b0;
			outCmd   <= cmdInvOp;
			outIdx   <= idxNone;
			outRegN  <= '0;
			outRegM  <= '0;
			outRegO  <= '0;
			outImm   <= '0;
			outWidth <= 3'b000;
		end else if (inReady) begin
			outValid <= inValid;
			if (inValid) begin
				outCmd   <= selCmd;
				outIdx   <= selIdx;
				outRegN  <= selRegN;
				outRegM  <= selRegM;
				outRegO  <= selRegO;
				outImm   <= selImm;
				outWidth <= clsWidth;
			end
		end
	end

	if (StallAssertions) begin : gStall
		// back-pressure freezes the whole output slot
		stallCheck: assert property (@(posedge clock) disable iff (rst)
			outValid && !outReady |=>
				outValid && $stable(outCmd) && $stable(outIdx) && $stable(outImm) &&
				$stable(outRegN) && $stable(outRegM) && $stable(outRegO) &&
				$stable(outWidth));
	end

endmodule

// File: test/rvDecodeTb.sv
// needs assertions compiled in; LFSR stimulus is repeatable and every wait gives up after WaitLimit cycles
`timescale 1ns/1ps

module rvDecodeTb;
	import rvDecodePkg::*;

	localparam int WaitLimit = 200;
	localparam uIdx_t AluTable [8] = '{idxAdd, idxShl, idxSlts, idxSltu,
		idxXor, idxShr, idxOr, idxAnd};
	localparam uIdx_t MulTable [8] = '{idxMul, idxMulhs, idxMulhsu, idxMulhu,
		idxDivs, idxDivu, idxMods, idxModu};
	localparam uIdx_t BranchTable [8] = '{idxEq, idxNe, idxEq, idxEq,
		idxLt, idxGe, idxLtu, idxGeu};

	logic clock;
	logic rst;
	logic inValid;
	logic [31:0] inWord;
	logic userMode;
	logic outReady;
	logic inReady;
	logic outValid;
	uCmd_t outCmd;
	uIdx_t outIdx;
	regIdx_t outRegN;
	regIdx_t outRegM;
	regIdx_t outRegO;
	imm_t outImm;
	logic [2:0] outWidth;

	// expected micro-op of the oldest word in flight
	logic expValid;
	uCmd_t expCmd;
	uIdx_t expIdx;
	regIdx_t expRegN;
	regIdx_t expRegM;
	regIdx_t expRegO;
	imm_t expImm;
	logic [2:0] expWidth;

	// accepted words, user mode bit on top
	logic [32:0] pending [$];
	int acceptCount = 0;
	int leaveCount = 0;
	int errCount = 0;
	int testErrStart = 0;
	int testCount = 0;
	int failedTests = 0;
	logic [31:0] lfsrState;
	logic stallOn;
	string testName = "reset";

	rvDecodeStage #(
		.StallAssertions(1'b1)
	) uut (
		.clock(clock),
		.rst(rst),
		.inValid(inValid),
		.inWord(inWord),
		.userMode(userMode),
		.outReady(outReady),
		.inReady(inReady),
		.outValid(outValid),
		.outCmd(outCmd),
		.outIdx(outIdx),
		.outRegN(outRegN),
		.outRegM(outRegM),
		.outRegO(outRegO),
		.outImm(outImm),
		.outWidth(outWidth)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic logic randBit();
		lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
		return lfsrState[0];
	endfunction

	function automatic logic [31:0] randBits(input int count);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < count; i++) begin
			v = {v[30:0], randBit()};
		end
		return v;
	endfunction

	function automatic logic [31:0] opWord(input logic [6:0] opc);
		logic [31:0] r;
		r = randBits(25);
		return {r[24:0], opc};
	endfunction

	// one of the ten kept major opcodes
	function automatic logic [31:0] keptWord();
		logic [31:0] r;
		logic [6:0] opc;
		r = randBits(4);
		case (r[3:0])
			4'd0: opc = 7'h03;
			4'd1: opc = 7'h23;
			4'd2: opc = 7'h63;
			4'd3: opc = 7'h67;
			4'd4, 4'd10: opc = 7'h6F;
			4'd5, 4'd11: opc = 7'h13;
			4'd6, 4'd12: opc = 7'h33;
			4'd7, 4'd13: opc = 7'h17;
			4'd8, 4'd14: opc = 7'h37;
			default: opc = 7'h73;
		endcase
		return opWord(opc);
	endfunction

	// field already sits at the top of v
	function automatic imm_t topSigned(input logic [31:0] v, input int shift);
		logic signed [32:0] t;
		t = {v[31], v};
		t = t >>> shift;
		return t;
	endfunction

	function automatic regIdx_t aliasReg(input logic [4:0] field);
		case (field)
			5'd0: return regZzr;
			5'd1: return regLr;
			5'd2: return regSp;
			5'd3: return regGbr;
			5'd4: return regTbr;
			5'd5: return regDhr;
			5'd14: return 7'd2;
			5'd15: return 7'd3;
			default: return {2'b00, field};
		endcase
	endfunction

	function automatic regIdx_t csrReg(input logic [11:0] csr);
		if (csr[11:6] == 6'b011111) begin
			return 7'd64 + {2'b00, csr[4:0]} + (csr[5] ? 7'd0 : 7'd32);
		end
		if (csr[11:6] == 6'b101111 || csr[11:6] == 6'b111111) begin
			return {1'b0, csr[5:0]};
		end
		return regZzr;
	endfunction

	task automatic decodeRef(input logic [32:0] entry, output uCmd_t cmd, output uIdx_t idx,
			output regIdx_t n, output regIdx_t m, output regIdx_t o, output imm_t imm,
			output logic [2:0] width);
		logic [31:0] w;
		logic [2:0] f3;
		w = entry[31:0];
		f3 = w[14:12];
		cmd = cmdInvOp;
		idx = idxNone;
		n = regZzr;
		m = regZzr;
		o = regZzr;
		imm = '0;
		width = 3'b000;
		if (w[1:0] == 2'b11) begin
			case (w[6:0])
				7'h03, 7'h23: begin
					cmd = w[5] ? cmdMovRm : cmdMovMr;
					n = w[5] ? aliasReg(w[24:20]) : aliasReg(w[11:7]);
					m = aliasReg(w[19:15]);
					o = regImm;
					imm = w[5] ? topSigned({w[31:25], w[11:7], 20'h0}, 20) : topSigned(w, 20);
					width = f3;
				end
				7'h63: begin
					cmd = cmdJcmp;
					idx = BranchTable[f3];
					m = aliasReg(w[19:15]);
					o = aliasReg(w[24:20]);
					imm = topSigned({w[31], w[7], w[30:25], w[11:8], 20'h0}, 20);
				end
				7'h67, 7'h6F, 7'h17: begin
					cmd = (w[11:7] == 5'd0) ? cmdJmp : cmdJsr;
					n = aliasReg(w[11:7]);
					m = regPc;
					o = regImm;
					imm = topSigned({w[31], w[19:12], w[20], w[30:21], 12'h0}, 12);
					if (w[6:0] == 7'h67) begin
						m = aliasReg(w[19:15]);
						imm = topSigned(w, 20);
					end
					if (w[6:0] == 7'h17) begin
						cmd = cmdLeaMr;
						imm = {1'b0, w[31:12], 12'h000};
					end
				end
				7'h13, 7'h33: begin
					cmd = (f3 == 3'b001 || f3 == 3'b101) ? cmdShad3 : cmdAlu3;
					idx = AluTable[f3];
					if (w[30] && f3 == 3'b101) begin
						idx = idxSar;
					end
					n = aliasReg(w[11:7]);
					m = aliasReg(w[19:15]);
					o = regImm;
					imm = topSigned(w, 20);
					if (w[5]) begin
						o = aliasReg(w[24:20]);
						imm = '0;
						if (w[30] && f3 == 3'b000) begin
							idx = idxSub;
						end
						if (w[31:25] == 7'd1) begin
							cmd = cmdMulDiv;
							idx = MulTable[f3];
						end
					end
				end
				7'h37: begin
					cmd = cmdMovIr;
					n = aliasReg(w[11:7]);
					m = regImm;
					imm = {1'b0, w[31:12], 12'h000};
				end
				7'h73: begin
					if (f3 == 3'b000 && w[23:20] inside {4'd0, 4'd1, 4'd2, 4'd5}) begin
						cmd = cmdIxt;
						case (w[23:20])
							4'd0: idx = idxSyscall;
							4'd1: idx = idxBreak;
							4'd2: idx = idxRte;
							default: idx = idxSleep;
						endcase
					end else if (f3 == 3'b001 && w[11:7] == 5'd0) begin
						cmd = cmdMovRc;
						n = csrReg(w[31:20]);
						m = aliasReg(w[19:15]);
						o = aliasReg(w[24:20]);
					end else if (f3 == 3'b010 && w[31:26] == 6'b111111) begin
						cmd = cmdIxt;
						idx = idxCpuid;
						n = aliasReg(w[11:7]);
						m = csrReg(w[31:20]);
						o = regCpuid;
					end else if (f3[2:1] == 2'b01 && w[19:15] == 5'd0) begin
						cmd = cmdMovCr;
						n = aliasReg(w[11:7]);
						m = csrReg(w[31:20]);
						o = aliasReg(w[24:20]);
					end
				end
				default: begin
					cmd = cmdInvOp;
				end
			endcase
		end
		// user mode may not write register field 4
		if (entry[32] && w[11:7] == 5'd4) begin
			cmd = cmdInvOp;
		end
	endtask

	function automatic string uopText(input logic [5:0] cmd, input logic [5:0] idx,
			input logic [6:0] n, input logic [6:0] m, input logic [6:0] o,
			input logic [32:0] imm, input logic [2:0] width);
		return $sformatf("cmd=%0d idx=%0d N=%h M=%h O=%h imm=%h width=%0d",
			cmd, idx, n, m, o, imm, width);
	endfunction

	always @(posedge clock) begin
		if (!rst) begin
			if (outValid && outReady) begin
				leaveCount++;
				if (pending.size() > 0) begin
					void'(pending.pop_front());
				end
			end
			if (inValid && inReady) begin
				pending.push_back({userMode, inWord});
				acceptCount++;
			end
		end
	end

	always @(negedge clock) begin
		expValid = pending.size() > 0;
		if (expValid) begin
			decodeRef(pending[0], expCmd, expIdx, expRegN, expRegM, expRegO, expImm, expWidth);
		end
	end

	validCheck: assert property (@(posedge clock) disable iff (rst) outValid == expValid)
	else begin
		$display("[FAIL] %s: expected outValid %b, actual %b", testName,
			$sampled(expValid), $sampled(outValid));
		errCount++;
	end

	dataCheck: assert property (@(posedge clock) disable iff (rst)
		outValid |-> outCmd == expCmd && outIdx == expIdx && outRegN == expRegN &&
			outRegM == expRegM && outRegO == expRegO && outImm == expImm &&
			outWidth == expWidth)
	else begin
		$display("[FAIL] %s: expected %s, actual %s", testName,
			uopText($sampled(expCmd), $sampled(expIdx), $sampled(expRegN), $sampled(expRegM),
				$sampled(expRegO), $sampled(expImm), $sampled(expWidth)),
			uopText($sampled(outCmd), $sampled(outIdx), $sampled(outRegN), $sampled(outRegM),
				$sampled(outRegO), $sampled(outImm), $sampled(outWidth)));
		errCount++;
	end

	// slot is free when no word is in flight, or when the held result leaves
	readyCheck: assert property (@(posedge clock) disable iff (rst)
		inReady == (!expValid || outReady))
	else begin
		$display("%s: inReady does not match the free or leaving output slot", testName);
		errCount++;
	end

	latencyCheck: assert property (@(posedge clock) disable iff (rst)
		inValid && inReady |=> outValid)
	else begin
		$display("%s: no result one cycle after an accepted word", testName);
		errCount++;
	end

	holdCheck: assert property (@(posedge clock) disable iff (rst)
		outValid && !outReady |=>
			outValid && $stable(outCmd) && $stable(outIdx) && $stable(outImm) &&
			$stable(outRegN) && $stable(outRegM) && $stable(outRegO) && $stable(outWidth))
	else begin
		$display("%s: outputs moved while the result was stalled", testName);
		errCount++;
	end

	task automatic abortRun(input string reason);
		$display("%s: %s", testName, reason);
		$display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errCount);
		$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic nextCycle();
		@(posedge clock);
		@(negedge clock);
		outReady = stallOn ? randBit() : 1'b1;
	endtask

	task automatic applyReset();
		rst = 1'b1;
		repeat (3) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
	endtask

	task automatic sendWord(input logic [31:0] word, input logic mode);
		int startCount;
		int waited;
		inValid = 1'b1;
		inWord = word;
		userMode = mode;
		startCount = acceptCount;
		waited = 0;
		while (acceptCount == startCount) begin
			if (waited >= WaitLimit) begin
				abortRun("timed out waiting for the stage to accept a word");
			end
			nextCycle();
			waited++;
		end
		inValid = 1'b0;
	endtask

	task automatic drain();
		int waited;
		inValid = 1'b0;
		waited = 0;
		while (acceptCount != leaveCount) begin
			if (waited >= WaitLimit) begin
				abortRun("timed out waiting for the results to leave");
			end
			nextCycle();
			waited++;
		end
	endtask

	task automatic beginTest(input string name);
		testName = name;
		testErrStart = errCount;
	endtask

	task automatic finishTest();
		drain();
		testCount++;
		if (errCount == testErrStart) begin
			$display("test %s: ok", testName);
		end else begin
			failedTests++;
			$display("test %s: %0d errors", testName, errCount - testErrStart);
		end
	endtask

	task automatic aluTest();
		logic [31:0] w;
		beginTest("integer ALU");
		for (int i = 0; i < 32; i++) begin
			w = opWord(i[0] ? 7'h33 : 7'h13);
			// keep OP out of the multiply/divide group
			if (i[0]) begin
				w[31:25] = {1'b0, w[30], 5'b00000};
			end
			sendWord(w, 1'b0);
		end
		finishTest();
	endtask

	task automatic memTest();
		beginTest("loads and stores");
		for (int i = 0; i < 24; i++) begin
			sendWord(opWord(i[0] ? 7'h23 : 7'h03), 1'b0);
		end
		finishTest();
	endtask

	task automatic flowTest();
		logic [31:0] w;
		beginTest("control flow and upper immediates");
		for (int i = 0; i < 16; i++) begin
			w = opWord(7'h63);
			w[14:12] = i[2:0];
			sendWord(w, 1'b0);
		end
		for (int i = 0; i < 16; i++) begin
			w = opWord(i[0] ? 7'h6F : 7'h67);
			if (i[1]) begin
				w[11:7] = 5'd0;
			end
			sendWord(w, 1'b0);
		end
		for (int i = 0; i < 12; i++) begin
			sendWord(opWord(i[0] ? 7'h17 : 7'h37), 1'b0);
		end
		finishTest();
	endtask

	task automatic aliasTest();
		logic [31:0] w;
		beginTest("register aliasing and user-mode refusal");
		for (int i = 0; i < 32; i++) begin
			w = opWord(7'h33);
			w[11:7] = i[4:0];
			w[19:15] = i[4:0];
			w[24:20] = 5'd31 - i[4:0];
			sendWord(w, 1'b0);
		end
		// rd 4 against rd 5, in both modes
		for (int i = 0; i < 24; i++) begin
			w = keptWord();
			w[11:7] = i[2] ? 5'd5 : 5'd4;
			sendWord(w, i[0]);
		end
		finishTest();
	endtask

	task automatic systemTest();
		logic [31:0] w;
		beginTest("system, multiply/divide and invalid words");
		for (int i = 0; i < 16; i++) begin
			w = opWord(7'h73);
			w[14:12] = 3'b000;
			w[23:20] = i[3:0];
			sendWord(w, 1'b0);
		end
		for (int i = 0; i < 32; i++) begin
			w = opWord(7'h73);
			w[14:12] = (i % 3 == 0) ? 3'b001 : ((i % 3 == 1) ? 3'b010 : 3'b011);
			case (i[4:3])
				2'd0: w[31:26] = 6'b011111;
				2'd1: w[31:26] = 6'b101111;
				2'd2: w[31:26] = 6'b111111;
				default: w[31:26] = w[31:26];
			endcase
			if (i[0]) begin
				w[11:7] = 5'd0;
				w[19:15] = 5'd0;
			end
			sendWord(w, 1'b0);
		end
		for (int i = 0; i < 16; i++) begin
			w = opWord(7'h33);
			w[31:25] = 7'd1;
			w[14:12] = i[2:0];
			sendWord(w, 1'b0);
		end
		for (int i = 0; i < 8; i++) begin
			w = randBits(32);
			w[1:0] = i[1:0] ^ {1'b0, &i[1:0]};
			sendWord(w, 1'b0);
		end
		// major opcodes outside the kept set
		sendWord(opWord(7'h07), 1'b0);
		sendWord(opWord(7'h0F), 1'b0);
		sendWord(opWord(7'h1B), 1'b0);
		sendWord(opWord(7'h2F), 1'b0);
		sendWord(opWord(7'h3B), 1'b0);
		sendWord(opWord(7'h53), 1'b0);
		finishTest();
	endtask

	task automatic handshakeTest();
		beginTest("handshake");
		applyReset();
		assert (!outValid && outCmd == cmdInvOp && outIdx == idxNone && outImm == '0 &&
				outRegN == '0 && outRegM == '0 && outRegO == '0 && outWidth == 3'b000)
		else begin
			$display("[FAIL] %s: expected outValid 0 and %s, actual outValid %b and %s",
				testName, uopText(6'd0, 6'd0, 7'd0, 7'd0, 7'd0, 33'd0, 3'd0), outValid,
				uopText(outCmd, outIdx, outRegN, outRegM, outRegO, outImm, outWidth));
			errCount++;
		end
		stallOn = 1'b1;
		for (int i = 0; i < 64; i++) begin
			if (randBit()) begin
				nextCycle();
			end
			sendWord(keptWord(), randBit());
		end
		finishTest();
		stallOn = 1'b0;
	endtask

	initial begin
		lfsrState = 32'h3295_4663;
		rst = 1'b1;
		inValid = 1'b0;
		inWord = '0;
		userMode = 1'b0;
		outReady = 1'b1;
		stallOn = 1'b0;
		applyReset();
		aluTest();
		memTest();
		flowTest();
		aliasTest();
		systemTest();
		handshakeTest();
		$display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errCount);
		if (errCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: compile.f
common/rvDecodePkg.sv
decode/regFieldMap.sv
decode/opClassify.sv
decode/operandSelect.sv
logic/rvDecodeStage.sv
test/rvDecodeTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= rvDecodeTb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell cat $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@$(SIM) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then exit 1; fi
	@if ! grep -q "simulator exit status 0" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
